// ==== Bender.yml ====
package:
  name: issue_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isaPkg.sv
      - hdl/pipePkg.sv
      - hdl/hazardDet.sv
      - hdl/stageTracker.sv
      - hdl/issueCtrl.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/issueCtrlProps.sv
      - test/issueCtrlTb.sv

// ==== hdl/hazardDet.sv ====
// hazard detector, issues the fetched word or a NOP and raises stall and forward selects

`include "issue_defs.svh"

module hazardDet (
    input  logic           rst,
    input  isaPkg::instS   fetchInst,
    input  pipePkg::pipeS  pipe,
    output isaPkg::instS   nextInst,
    output logic           pcStall,
    output pipePkg::fwdS   fwd
);

    // one stage record against one source field
    function automatic logic hitStage(
        input pipePkg::stageS   s,
        input logic [`REG_W-1:0] src
    );
        return s.regWrt && (s.wrtReg == src);
    endfunction

    // rs compares
    logic rsHitD;
    logic rsHitXM;
    // field 7..5 compares, rt or the store data register
    logic rtHitD;
    logic rtHitXM;
    // a control transfer anywhere in D through W
    logic anyBranch;

    // decision of this cycle
    logic stall;
    logic fwdA;
    logic fwdB;

    // writer in D is one stage ahead and can be forwarded ex to ex
    assign rsHitD  = hitStage(pipe.d, fetchInst.rs);
    assign rtHitD  = hitStage(pipe.d, fetchInst.rt);

    // writers in X and M are too close for the forward path
    assign rsHitXM = hitStage(pipe.x, fetchInst.rs) | hitStage(pipe.m, fetchInst.rs);
    assign rtHitXM = hitStage(pipe.x, fetchInst.rt) | hitStage(pipe.m, fetchInst.rt);

    // W writers are bypassed inside the register file, only the branch flag counts there
    // no branch resolution here, so a transfer drains all the way through W
    assign anyBranch = pipe.d.branch | pipe.x.branch | pipe.m.branch | pipe.w.branch;

    // per-class stall and forward decode
    always_comb begin
        stall = 1'b0;
        fwdA  = 1'b0;
        fwdB  = 1'b0;

        case (fetchInst.opcode)
            // two sources, rs and field 7..5
            isaPkg::ST,
            isaPkg::STU,
            isaPkg::ARITH,
            isaPkg::LOGIC,
            isaPkg::SEQ,
            isaPkg::SLT,
            isaPkg::SLE,
            isaPkg::SCO: begin
                stall = rsHitXM | rtHitXM | anyBranch;
                // D writer feeds both operands over the ex to ex path
                fwdA  = rsHitD;
                fwdB  = rtHitD;
            end

            // rs plus control, conditional branches and register jumps
            isaPkg::BEQZ,
            isaPkg::BNEZ,
            isaPkg::BLTZ,
            isaPkg::BGEZ,
            isaPkg::JR,
            isaPkg::JALR: begin
                stall = rsHitXM | anyBranch;
                fwdA  = rsHitD;
            end

            // nothing read from the register file
            isaPkg::J,
            isaPkg::JAL,
            isaPkg::LBI,
            isaPkg::HALT,
            isaPkg::NOP: begin
                stall = anyBranch;
            end

            // exception entry and return go straight through
            isaPkg::SIIC,
            isaPkg::RTI: begin
                stall = 1'b0;
            end

            // immediate ops, loads, SLBI and BTR read rs only
            // no forward path for these, so a D writer stalls as well
            default: begin
                stall = rsHitD | rsHitXM | anyBranch;
            end
        endcase
    end

    // PC freezes for every stalled cycle
    assign pcStall = stall;

    // selects go out even on a stalled cycle, decode drops them with the NOP
    assign fwd.fwdA = fwdA;
    assign fwd.fwdB = fwdB;

    // bubble in place of the fetched word on stall or reset
    assign nextInst = (stall || rst) ? isaPkg::instS'(`NOP_INST) : fetchInst;

endmodule

// ==== hdl/isaPkg.sv ====
// ISA package with the opcode encodings and the instruction field layout

`include "issue_defs.svh"

package isaPkg;

    // 5-bit opcodes, all 32 codes are assigned
    typedef enum logic [`OPC_W-1:0] {
        // machine control
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        SIIC  = 5'b00010,
        RTI   = 5'b00011,
        // jumps, direct and register
        J     = 5'b00100,
        JR    = 5'b00101,
        JAL   = 5'b00110,
        JALR  = 5'b00111,
        // immediate alu ops on rs
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        // conditional branches on rs
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        BLTZ  = 5'b01110,
        BGEZ  = 5'b01111,
        // memory and byte immediates
        ST    = 5'b10000,
        LD    = 5'b10001,
        SLBI  = 5'b10010,
        STU   = 5'b10011,
        // immediate shifts and rotates
        ROLI  = 5'b10100,
        SLLI  = 5'b10101,
        RORI  = 5'b10110,
        SRLI  = 5'b10111,
        // register forms
        LBI   = 5'b11000,
        BTR   = 5'b11001,
        LOGIC = 5'b11010,
        ARITH = 5'b11011,
        // set group, compare rs against rt
        SEQ   = 5'b11100,
        SLT   = 5'b11101,
        SLE   = 5'b11110,
        SCO   = 5'b11111
    } opcodeE;

    // fields from msb down, rt doubles as rd for the immediate forms
    typedef struct packed {
        opcodeE                                  opcode;
        logic [`REG_W-1:0]                       rs;
        logic [`REG_W-1:0]                       rt;
        logic [`REG_W-1:0]                       rd;
        logic [`INST_W-`OPC_W-3*`REG_W-1:0]      low;
    } instS;

endpackage

// ==== hdl/issueCtrl.sv ====
// issue control top, hazard detector fed by the stage tracker of the issued stream

`include "issue_defs.svh"

module issueCtrl (
    input  logic          clk,
    input  logic          rst,
    input  isaPkg::instS  fetchInst,
    output isaPkg::instS  nextInst,
    output logic          pcStall,
    output pipePkg::fwdS  fwd
);

    // stage records of D, X, M and W
    pipePkg::pipeS pipe;

    // zero-latency issue decision
    hazardDet hazardDet0 (
        .rst       (rst),
        .fetchInst (fetchInst),
        .pipe      (pipe),
        .nextInst  (nextInst),
        .pcStall   (pcStall),
        .fwd       (fwd)
    );

    // tracks what was actually issued, bubbles included
    stageTracker stageTracker0 (
        .clk    (clk),
        .rst    (rst),
        .issued (nextInst),
        .pipe   (pipe)
    );

endmodule

// ==== hdl/issue_defs.svh ====
// issue control widths and the NOP word shared by the packages, RTL and testbench

`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// full instruction word width
`define INST_W 16

// register index width, eight architectural registers
`define REG_W 3

// opcode field width at the top of the word
`define OPC_W 5

// NOP is opcode 00001 with every other bit zero
// NOTE the low part tracks INST_W so the word stays full width
`define NOP_INST {5'b00001, {(`INST_W - `OPC_W){1'b0}}}

// register written by the link of JAL and JALR
`define LINK_REG {`REG_W{1'b1}}

`endif

// ==== hdl/pipePkg.sv ====
// pipeline package with the per-stage writer record and the forwarding selects

`include "issue_defs.svh"

package pipePkg;

    // what one in-flight instruction means to the hazard logic
    typedef struct packed {
        // slot writes a register
        logic              regWrt;
        // destination index, only meaningful with regWrt
        logic [`REG_W-1:0] wrtReg;
        // slot is a jump or branch
        logic              branch;
    } stageS;

    // records of the four stages behind fetch
    typedef struct packed {
        stageS d;
        stageS x;
        stageS m;
        stageS w;
    } pipeS;

    // execute to execute forward selects
    typedef struct packed {
        // operand A comes from the D writer
        logic fwdA;
        // operand B comes from the D writer
        logic fwdB;
    } fwdS;

endpackage

// ==== hdl/stageTracker.sv ====
// stage tracker, shifts the writer and control record of each issued word through D to W

`include "issue_defs.svh"

module stageTracker (
    input  logic          clk,
    input  logic          rst,
    input  isaPkg::instS  issued,
    output pipePkg::pipeS pipe
);

    // destination and control flag of one issued word
    function automatic pipePkg::stageS decodeDest(input isaPkg::instS inst);
        pipePkg::stageS rec;
        rec = '0;

        case (inst.opcode)
            // register forms write field 4..2
            isaPkg::ARITH,
            isaPkg::LOGIC,
            isaPkg::SEQ,
            isaPkg::SLT,
            isaPkg::SLE,
            isaPkg::SCO: begin
                rec.regWrt = 1'b1;
                rec.wrtReg = inst.rd;
            end

            // immediate alu ops, load and bit reverse write field 7..5
            isaPkg::ADDI,
            isaPkg::SUBI,
            isaPkg::XORI,
            isaPkg::ANDNI,
            isaPkg::ROLI,
            isaPkg::SLLI,
            isaPkg::RORI,
            isaPkg::SRLI,
            isaPkg::LD,
            isaPkg::BTR: begin
                rec.regWrt = 1'b1;
                rec.wrtReg = inst.rt;
            end

            // byte immediates and store-update write back into rs
            isaPkg::LBI,
            isaPkg::SLBI,
            isaPkg::STU: begin
                rec.regWrt = 1'b1;
                rec.wrtReg = inst.rs;
            end

            // linking jumps, return address goes to r7
            isaPkg::JAL,
            isaPkg::JALR: begin
                rec.regWrt = 1'b1;
                rec.wrtReg = `LINK_REG;
                rec.branch = 1'b1;
            end

            // plain jumps and the four conditional branches
            isaPkg::J,
            isaPkg::JR,
            isaPkg::BEQZ,
            isaPkg::BNEZ,
            isaPkg::BLTZ,
            isaPkg::BGEZ: begin
                rec.branch = 1'b1;
            end

            // HALT, NOP, SIIC, RTI and ST leave no register write behind
            default: begin
                rec = '0;
            end
        endcase

        return rec;
    endfunction

    // record of the word entering D this clock
    pipePkg::stageS issuedRec;

    // a stall bubble decodes to an all-zero record
    assign issuedRec = decodeDest(issued);

    // four-deep shift, advances every clock, stalls included
    always_ff @(posedge clk) begin
        if (rst) begin
            // empty pipeline, no writers and no transfers
            pipe <= '0;
        end else begin
            pipe.d <= issuedRec;
            pipe.x <= pipe.d;
            pipe.m <= pipe.x;
            pipe.w <= pipe.m;
        end
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/hazardDet.sv
hdl/stageTracker.sv
hdl/issueCtrl.sv
test/issueCtrlProps.sv
test/issueCtrlTb.sv

// ==== test/issueCtrlProps.sv ====
// issue control properties, NOP on stall or reset, clean outputs after reset, fwdB only on two sources

`include "issue_defs.svh"

module issueCtrlProps (
    input logic          clk,
    input logic          rst,
    input isaPkg::instS  fetchInst,
    input isaPkg::instS  nextInst,
    input logic          pcStall,
    input pipePkg::fwdS  fwd
);

    // read back by the testbench at the end of the run
    int assertFails = 0;

    // bubble whenever the PC is frozen or the core is in reset
    nopOnStall: assert property (@(posedge clk)
        (pcStall || rst) |-> (nextInst == isaPkg::instS'(`NOP_INST)))
        else begin
            $error("nextInst is not the NOP during stall or reset");
            assertFails++;
        end

    // tracker is empty one cycle after reset
    quietAfterRst: assert property (@(posedge clk)
        rst |=> (!pcStall && (fwd == '0)))
        else begin
            $error("pcStall or fwd set in the cycle after reset");
            assertFails++;
        end

    // operand B path only exists for the two-source class
    fwdBTwoSrc: assert property (@(posedge clk) disable iff (rst)
        fwd.fwdB |-> (fetchInst.opcode inside {isaPkg::ST, isaPkg::STU, isaPkg::ARITH,
                                               isaPkg::LOGIC, isaPkg::SEQ, isaPkg::SLT,
                                               isaPkg::SLE, isaPkg::SCO}))
        else begin
            $error("fwdB raised for an opcode without a second source");
            assertFails++;
        end

endmodule

bind issueCtrl issueCtrlProps props0 (
    .clk       (clk),
    .rst       (rst),
    .fetchInst (fetchInst),
    .nextInst  (nextInst),
    .pcStall   (pcStall),
    .fwd       (fwd)
);

// ==== test/issueCtrlTb.sv ====
// issue control testbench, directed hazard cases and a seeded random stream checked by a model

`include "issue_defs.svh"

module issueCtrlTb;

    localparam int RESET_CYC = 8;
    localparam int DIR_WORDS = 18;
    localparam int HOLD_MAX  = 6;
    localparam int RAND_CYC  = 3000;
    // every directed word may wait out a full drain
    localparam int TOTAL_CYC = RESET_CYC + DIR_WORDS * (HOLD_MAX + 1) + RAND_CYC;

    logic          clk;
    logic          rst;
    isaPkg::instS  fetchInst;
    isaPkg::instS  nextInst;
    logic          pcStall;
    pipePkg::fwdS  fwd;

    // model state, D X M W records of what was issued
    pipePkg::pipeS     modelPipe;
    logic              lastStall;
    logic [31:0]       rngState;
    isaPkg::opcodeE    commonOps [10];

    issueCtrl dut0 (
        .clk       (clk),
        .rst       (rst),
        .fetchInst (fetchInst),
        .nextInst  (nextInst),
        .pcStall   (pcStall),
        .fwd       (fwd)
    );

    always #2 clk = ~clk;

    // LCG step, upper bits are the useful ones
    function logic [31:0] nextRand();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState;
    endfunction

    // mostly r0..r3 so fields collide, sometimes the full range
    function automatic logic [`REG_W-1:0] pickReg(input logic [3:0] bits);
        return bits[3] ? bits[2:0] : {1'b0, bits[1:0]};
    endfunction

    function automatic isaPkg::instS makeInst(
        input isaPkg::opcodeE    op,
        input logic [`REG_W-1:0] rs,
        input logic [`REG_W-1:0] rt,
        input logic [`REG_W-1:0] rd
    );
        isaPkg::instS inst;
        inst = '0;
        inst.opcode = op;
        inst.rs = rs;
        inst.rt = rt;
        inst.rd = rd;
        return inst;
    endfunction

    function automatic isaPkg::instS randInst();
        logic [31:0]  r;
        isaPkg::instS inst;
        r = nextRand();
        // three in four draws come from the register heavy list
        if (r[31:30] != 2'b00) begin
            inst.opcode = commonOps[r[29:26] % 10];
        end else begin
            inst.opcode = isaPkg::opcodeE'(r[25:21]);
        end
        inst.rs = pickReg(r[20:17]);
        inst.rt = pickReg(r[16:13]);
        inst.rd = pickReg(r[12:9]);
        inst.low = r[8:7];
        return inst;
    endfunction

    function automatic logic writesReg(input pipePkg::stageS s, input logic [`REG_W-1:0] r);
        return s.regWrt && (s.wrtReg == r);
    endfunction

    // destination rule, what an issued word leaves in D
    function automatic pipePkg::stageS modelDest(input isaPkg::instS inst);
        pipePkg::stageS rec;
        rec = '0;
        if (inst.opcode inside {isaPkg::ARITH, isaPkg::LOGIC, isaPkg::SEQ, isaPkg::SLT,
                                isaPkg::SLE, isaPkg::SCO}) begin
            rec.regWrt = 1'b1;
            rec.wrtReg = inst.rd;
        end else if (inst.opcode inside {isaPkg::ADDI, isaPkg::SUBI, isaPkg::XORI,
                                         isaPkg::ANDNI, isaPkg::ROLI, isaPkg::SLLI,
                                         isaPkg::RORI, isaPkg::SRLI, isaPkg::LD,
                                         isaPkg::BTR}) begin
            rec.regWrt = 1'b1;
            rec.wrtReg = inst.rt;
        end else if (inst.opcode inside {isaPkg::LBI, isaPkg::SLBI, isaPkg::STU}) begin
            rec.regWrt = 1'b1;
            rec.wrtReg = inst.rs;
        end else if (inst.opcode inside {isaPkg::JAL, isaPkg::JALR}) begin
            // link register
            rec.regWrt = 1'b1;
            rec.wrtReg = 3'd7;
        end
        rec.branch = inst.opcode inside {isaPkg::J, isaPkg::JR, isaPkg::JAL, isaPkg::JALR,
                                         isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ,
                                         isaPkg::BGEZ};
        return rec;
    endfunction

    // detector table by opcode class
    function automatic void modelIssue(
        input  isaPkg::instS  inst,
        input  pipePkg::pipeS p,
        input  logic          rstIn,
        output isaPkg::instS  expInst,
        output logic          expStall,
        output pipePkg::fwdS  expFwd
    );
        logic brAny;
        logic aD;
        logic aXM;
        logic bD;
        logic bXM;
        brAny = p.d.branch || p.x.branch || p.m.branch || p.w.branch;
        aD = writesReg(p.d, inst.rs);
        aXM = writesReg(p.x, inst.rs) || writesReg(p.m, inst.rs);
        bD = writesReg(p.d, inst.rt);
        bXM = writesReg(p.x, inst.rt) || writesReg(p.m, inst.rt);
        expFwd = '0;
        if (inst.opcode inside {isaPkg::SIIC, isaPkg::RTI}) begin
            expStall = 1'b0;
        end else if (inst.opcode inside {isaPkg::ST, isaPkg::STU, isaPkg::ARITH,
                                         isaPkg::LOGIC, isaPkg::SEQ, isaPkg::SLT,
                                         isaPkg::SLE, isaPkg::SCO}) begin
            expStall = aXM || bXM || brAny;
            expFwd.fwdA = aD;
            expFwd.fwdB = bD;
        end else if (inst.opcode inside {isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ,
                                         isaPkg::BGEZ, isaPkg::JR, isaPkg::JALR}) begin
            expStall = aXM || brAny;
            expFwd.fwdA = aD;
        end else if (inst.opcode inside {isaPkg::J, isaPkg::JAL, isaPkg::LBI, isaPkg::HALT,
                                         isaPkg::NOP}) begin
            expStall = brAny;
        end else begin
            // rs only, no forward path so a D writer stalls too
            expStall = aD || aXM || brAny;
        end
        expInst = (expStall || rstIn) ? isaPkg::instS'(`NOP_INST) : inst;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkInst(input string name, input isaPkg::instS exp, input isaPkg::instS act);
        if (act !== exp) begin
            failRun($sformatf("Mismatch %s nextInst: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkStall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            failRun($sformatf("Mismatch %s pcStall: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic checkFwd(input string name, input pipePkg::fwdS exp, input pipePkg::fwdS act);
        if (act !== exp) begin
            failRun($sformatf("Mismatch %s fwd: expected %b actual %b", name, exp, act));
        end
    endtask

    // one clock, drive on the falling edge, check mid-low, advance model on the rising edge
    task automatic stepCycle(input string name, input isaPkg::instS inst, input logic rstIn);
        isaPkg::instS expInst;
        logic         expStall;
        pipePkg::fwdS expFwd;
        @(negedge clk);
        rst = rstIn;
        fetchInst = inst;
        #1;
        modelIssue(inst, modelPipe, rstIn, expInst, expStall, expFwd);
        checkInst(name, expInst, nextInst);
        checkStall(name, expStall, pcStall);
        checkFwd(name, expFwd, fwd);
        lastStall = expStall;
        @(posedge clk);
        if (rstIn) begin
            modelPipe = '0;
        end else begin
            modelPipe.w = modelPipe.m;
            modelPipe.m = modelPipe.x;
            modelPipe.x = modelPipe.d;
            modelPipe.d = modelDest(expInst);
        end
    endtask

    // present a word and hold it until it issues
    task automatic issueWord(input string name, input isaPkg::instS inst);
        int tries;
        tries = 0;
        stepCycle(name, inst, 1'b0);
        while (lastStall) begin
            tries++;
            if (tries > HOLD_MAX) begin
                failRun($sformatf("%s: word %h never issued", name, inst));
            end
            stepCycle(name, inst, 1'b0);
        end
    endtask

    initial begin
        #(TOTAL_CYC * 4 + 200);
        $display("timeout: run exceeded %0d cycles", TOTAL_CYC);
        $display("FAIL: see errors above");
        $fatal(1);
    end

    initial begin
        isaPkg::instS cur;
        clk = 1'b0;
        rst = 1'b1;
        fetchInst = isaPkg::instS'(`NOP_INST);
        modelPipe = '0;
        lastStall = 1'b0;
        rngState = 32'h9ef2;
        commonOps = '{isaPkg::ADDI, isaPkg::ARITH, isaPkg::LOGIC, isaPkg::LD, isaPkg::ST,
                      isaPkg::STU, isaPkg::SLBI, isaPkg::XORI, isaPkg::SEQ, isaPkg::BTR};

        // random words under reset must still come out as NOP
        for (int i = 0; i < RESET_CYC; i++) begin
            stepCycle("reset", randInst(), 1'b1);
        end

        // D writer forwards, X then M writer stalls, W only issues
        issueWord("raw", makeInst(isaPkg::ADDI, 3'd0, 3'd1, 3'd0));
        issueWord("raw", makeInst(isaPkg::ARITH, 3'd1, 3'd2, 3'd3));
        issueWord("raw", makeInst(isaPkg::ADDI, 3'd0, 3'd2, 3'd0));
        issueWord("raw", makeInst(isaPkg::NOP, 3'd0, 3'd0, 3'd0));
        issueWord("raw", makeInst(isaPkg::LOGIC, 3'd2, 3'd3, 3'd4));

        // rs-only class cannot forward from D
        issueWord("forward", makeInst(isaPkg::ADDI, 3'd0, 3'd4, 3'd0));
        issueWord("forward", makeInst(isaPkg::XORI, 3'd4, 3'd5, 3'd0));
        // store data operand from the D writer
        issueWord("forward", makeInst(isaPkg::LD, 3'd3, 3'd6, 3'd0));
        issueWord("forward", makeInst(isaPkg::ST, 3'd1, 3'd6, 3'd0));

        issueWord("drain", makeInst(isaPkg::J, 3'd0, 3'd0, 3'd0));
        issueWord("drain", makeInst(isaPkg::ADDI, 3'd1, 3'd1, 3'd0));

        // exception words slip through the drain window
        issueWord("passThrough", makeInst(isaPkg::BEQZ, 3'd0, 3'd0, 3'd0));
        issueWord("passThrough", makeInst(isaPkg::SIIC, 3'd2, 3'd3, 3'd1));
        issueWord("passThrough", makeInst(isaPkg::RTI, 3'd5, 3'd6, 3'd7));
        issueWord("passThrough", makeInst(isaPkg::ADDI, 3'd2, 3'd2, 3'd0));

        // JAL link in D raises fwd on the stalled reader of r7
        issueWord("link", makeInst(isaPkg::JAL, 3'd0, 3'd0, 3'd0));
        issueWord("link", makeInst(isaPkg::ARITH, 3'd7, 3'd7, 3'd1));

        cur = randInst();
        for (int i = 0; i < RAND_CYC; i++) begin
            // fetch side holds its word while the PC is frozen
            if (!lastStall) begin
                cur = randInst();
            end
            stepCycle("random", cur, 1'b0);
        end

        if (dut0.props0.assertFails == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("%0d assertion failures in the bound properties", dut0.props0.assertFails);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

endmodule
